// ==== mem_read_top.f ====
+incdir+source
source/bus_pkg.sv
source/read_arbiter.sv
source/read_router.sv
source/clint_timer.sv
source/mem_read_top.sv
testbench/mem_read_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module mem_read_top_tb \
    -f mem_read_top.f -Mdir obj_dir || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vmem_read_top_tb)"
echo "$out"
grep -qx "All checks passed" <<< "$out" && exit 0 || exit 1

// ==== source/bus_consts.svh ====
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// core-local timer window, 64 KiB at the base
`define CLINT_BASE      32'h0200_0000
`define CLINT_SPAN_BITS 16

// mtime word offsets inside the window
`define MTIME_LO_OFF    16'h0000
`define MTIME_HI_OFF    16'h0004

// read response codes
`define RESP_OKAY       2'b00
`define RESP_DECERR     2'b11

`endif

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // read data word
    typedef logic [31:0] data_t;

    // read response code
    typedef logic [1:0] resp_t;

    // read request payload, travels with arvalid/arready
    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    // read response payload, travels with rvalid/rready
    typedef struct packed {
        data_t data;
        resp_t resp;
    } rd_rsp_t;

    // arbiter grant state
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_LSU  = 2'd1,
        ARB_IFU  = 2'd2
    } arb_state_t;

endpackage

// ==== source/clint_timer.sv ====
`timescale 1ns/10ps

`include "bus_consts.svh"

module clint_timer (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              arvalid,
    output logic              arready,
    input  bus_pkg::rd_req_t  ar,
    output logic              rvalid,
    input  logic              rready,
    output bus_pkg::rd_rsp_t  r
);

    import bus_pkg::*;

    logic [63:0]                 mtime;
    logic [`CLINT_SPAN_BITS-1:0] offset;
    rd_rsp_t                     rsp_next;
    rd_rsp_t                     rsp_q;
    logic                        rvalid_q;

    assign offset  = ar.addr[`CLINT_SPAN_BITS-1:0];
    assign arready = ~rvalid_q;
    assign rvalid  = rvalid_q;
    assign r       = rsp_q;

    // word select, anything else is a decode error
    always_comb begin
        if (offset == `MTIME_LO_OFF) begin
            rsp_next.data = mtime[31:0];
            rsp_next.resp = `RESP_OKAY;
        end else if (offset == `MTIME_HI_OFF) begin
            rsp_next.data = mtime[63:32];
            rsp_next.resp = `RESP_OKAY;
        end else begin
            rsp_next.data = '0;
            rsp_next.resp = `RESP_DECERR;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtime    <= 64'd0;
            rvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (arvalid && arready) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // response payload, sampled at the request handshake
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rsp_q <= rsp_next;
        end
    end

endmodule

// ==== source/mem_read_top.sv ====
`timescale 1ns/10ps

module mem_read_top (
    input  logic              clock,
    input  logic              arst_n,

    input  logic              ifu_arvalid,
    output logic              ifu_arready,
    input  bus_pkg::rd_req_t  ifu_ar,
    output logic              ifu_rvalid,
    input  logic              ifu_rready,
    output bus_pkg::rd_rsp_t  ifu_r,

    input  logic              lsu_arvalid,
    output logic              lsu_arready,
    input  bus_pkg::rd_req_t  lsu_ar,
    output logic              lsu_rvalid,
    input  logic              lsu_rready,
    output bus_pkg::rd_rsp_t  lsu_r,

    output logic              mst_arvalid,
    input  logic              mst_arready,
    output bus_pkg::rd_req_t  mst_ar,
    input  logic              mst_rvalid,
    output logic              mst_rready,
    input  bus_pkg::rd_rsp_t  mst_r
);

    import bus_pkg::*;

    // arbiter to router
    logic    gnt_arvalid;
    logic    gnt_arready;
    rd_req_t gnt_ar;
    logic    gnt_rvalid;
    logic    gnt_rready;
    rd_rsp_t gnt_r;

    // router to timer
    logic    clint_arvalid;
    logic    clint_arready;
    rd_req_t clint_ar;
    logic    clint_rvalid;
    logic    clint_rready;
    rd_rsp_t clint_r;

    read_arbiter u_arbiter (
        .clock       (clock),
        .arst_n      (arst_n),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_ar      (ifu_ar),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_r       (ifu_r),
        .lsu_arvalid (lsu_arvalid),
        .lsu_arready (lsu_arready),
        .lsu_ar      (lsu_ar),
        .lsu_rvalid  (lsu_rvalid),
        .lsu_rready  (lsu_rready),
        .lsu_r       (lsu_r),
        .gnt_arvalid (gnt_arvalid),
        .gnt_arready (gnt_arready),
        .gnt_ar      (gnt_ar),
        .gnt_rvalid  (gnt_rvalid),
        .gnt_rready  (gnt_rready),
        .gnt_r       (gnt_r)
    );

    read_router u_router (
        .clock         (clock),
        .arst_n        (arst_n),
        .gnt_arvalid   (gnt_arvalid),
        .gnt_arready   (gnt_arready),
        .gnt_ar        (gnt_ar),
        .gnt_rvalid    (gnt_rvalid),
        .gnt_rready    (gnt_rready),
        .gnt_r         (gnt_r),
        .mst_arvalid   (mst_arvalid),
        .mst_arready   (mst_arready),
        .mst_ar        (mst_ar),
        .mst_rvalid    (mst_rvalid),
        .mst_rready    (mst_rready),
        .mst_r         (mst_r),
        .clint_arvalid (clint_arvalid),
        .clint_arready (clint_arready),
        .clint_ar      (clint_ar),
        .clint_rvalid  (clint_rvalid),
        .clint_rready  (clint_rready),
        .clint_r       (clint_r)
    );

    clint_timer u_clint (
        .clock   (clock),
        .arst_n  (arst_n),
        .arvalid (clint_arvalid),
        .arready (clint_arready),
        .ar      (clint_ar),
        .rvalid  (clint_rvalid),
        .rready  (clint_rready),
        .r       (clint_r)
    );

endmodule

// ==== source/read_arbiter.sv ====
`timescale 1ns/10ps

module read_arbiter (
    input  logic              clock,
    input  logic              arst_n,

    input  logic              ifu_arvalid,
    output logic              ifu_arready,
    input  bus_pkg::rd_req_t  ifu_ar,
    output logic              ifu_rvalid,
    input  logic              ifu_rready,
    output bus_pkg::rd_rsp_t  ifu_r,

    input  logic              lsu_arvalid,
    output logic              lsu_arready,
    input  bus_pkg::rd_req_t  lsu_ar,
    output logic              lsu_rvalid,
    input  logic              lsu_rready,
    output bus_pkg::rd_rsp_t  lsu_r,

    output logic              gnt_arvalid,
    input  logic              gnt_arready,
    output bus_pkg::rd_req_t  gnt_ar,
    input  logic              gnt_rvalid,
    output logic              gnt_rready,
    input  bus_pkg::rd_rsp_t  gnt_r
);

    import bus_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       idle;
    logic       pick_lsu;
    logic       req_fire;
    logic       rsp_fire;

    assign idle     = (state == ARB_IDLE);
    // fixed priority, load/store first
    assign pick_lsu = lsu_arvalid;

    // request channel, only while idle
    assign gnt_arvalid = idle & (lsu_arvalid | ifu_arvalid);
    assign gnt_ar      = pick_lsu ? lsu_ar : ifu_ar;
    assign lsu_arready = idle & pick_lsu & gnt_arready;
    assign ifu_arready = idle & ~pick_lsu & gnt_arready;

    // response channel back to the owner of the grant
    assign lsu_rvalid = (state == ARB_LSU) & gnt_rvalid;
    assign ifu_rvalid = (state == ARB_IFU) & gnt_rvalid;
    assign lsu_r      = gnt_r;
    assign ifu_r      = gnt_r;

    always_comb begin
        case (state)
            ARB_LSU: gnt_rready = lsu_rready;
            ARB_IFU: gnt_rready = ifu_rready;
            default: gnt_rready = 1'b0;
        endcase
    end

    assign req_fire = gnt_arvalid & gnt_arready;
    assign rsp_fire = gnt_rvalid & gnt_rready;

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (req_fire) begin
                    state_next = pick_lsu ? ARB_LSU : ARB_IFU;
                end
            end
            ARB_LSU, ARB_IFU: begin
                // grant held until the response is taken
                if (rsp_fire) begin
                    state_next = ARB_IDLE;
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== source/read_router.sv ====
`timescale 1ns/10ps

`include "bus_consts.svh"

module read_router (
    input  logic              clock,
    input  logic              arst_n,

    input  logic              gnt_arvalid,
    output logic              gnt_arready,
    input  bus_pkg::rd_req_t  gnt_ar,
    output logic              gnt_rvalid,
    input  logic              gnt_rready,
    output bus_pkg::rd_rsp_t  gnt_r,

    output logic              mst_arvalid,
    input  logic              mst_arready,
    output bus_pkg::rd_req_t  mst_ar,
    input  logic              mst_rvalid,
    output logic              mst_rready,
    input  bus_pkg::rd_rsp_t  mst_r,

    output logic              clint_arvalid,
    input  logic              clint_arready,
    output bus_pkg::rd_req_t  clint_ar,
    input  logic              clint_rvalid,
    output logic              clint_rready,
    input  bus_pkg::rd_rsp_t  clint_r
);

    import bus_pkg::*;

    logic  hit_clint;
    logic  busy;
    logic  tgt_clint;
    logic  req_fire;
    logic  rsp_fire;

    // window decode on the upper address bits
    assign hit_clint = ((gnt_ar.addr >> `CLINT_SPAN_BITS) == (`CLINT_BASE >> `CLINT_SPAN_BITS));

    // request side blocked while a read is outstanding
    assign mst_arvalid   = gnt_arvalid & ~busy & ~hit_clint;
    assign clint_arvalid = gnt_arvalid & ~busy & hit_clint;
    assign mst_ar        = gnt_ar;
    assign clint_ar      = gnt_ar;
    assign gnt_arready   = ~busy & (hit_clint ? clint_arready : mst_arready);

    // response side from the latched target
    assign gnt_rvalid   = busy & (tgt_clint ? clint_rvalid : mst_rvalid);
    assign gnt_r        = tgt_clint ? clint_r : mst_r;
    assign clint_rready = busy & tgt_clint & gnt_rready;
    assign mst_rready   = ~tgt_clint & gnt_rready;

    assign req_fire = gnt_arvalid & gnt_arready;
    assign rsp_fire = gnt_rvalid & gnt_rready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            tgt_clint <= 1'b0;
        end else begin
            if (req_fire) begin
                busy      <= 1'b1;
                tgt_clint <= hit_clint;
            end else if (rsp_fire) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== testbench/mem_read_top_tb.sv ====
`timescale 1ns/10ps

`include "bus_consts.svh"

module mem_read_top_tb;

    import bus_pkg::*;

    // six tests of about 40 cycles each times eight
    localparam int TIMEOUT_CYCLES = 2000;
    localparam data_t DATA_MASK = 32'h5a5a_5a5a;

    logic        clock = 1'b0;
    logic        arst_n;
    logic        ifu_arvalid;
    logic        ifu_arready;
    logic        ifu_rvalid;
    logic        ifu_rready;
    logic        lsu_arvalid;
    logic        lsu_arready;
    logic        lsu_rvalid;
    logic        lsu_rready;
    logic        mst_arvalid;
    logic        mst_arready;
    logic        mst_rvalid;
    logic        mst_rready;
    rd_req_t     ifu_ar;
    rd_req_t     lsu_ar;
    rd_req_t     mst_ar;
    rd_rsp_t     ifu_r;
    rd_rsp_t     lsu_r;
    rd_rsp_t     mst_r;
    int          cycle = 0;
    int          errors = 0;
    int          req_count = 0;
    int          mst_av_cycles = 0;
    int          ifu_ar_hs = 0;
    logic [31:0] tb_lfsr = 32'hc993;
    logic [31:0] mem_lfsr = 32'hc993;

    mem_read_top UUT (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run stopped by timeout after %0d cycles, %0d errors", cycle, errors);
            $display("Checks failed");
            $finish;
        end
    end

    // activity counters sampled mid-cycle
    always @(negedge clock) begin
        if (ifu_arvalid && ifu_arready) ifu_ar_hs <= ifu_ar_hs + 1;
        if (mst_arvalid) mst_av_cycles <= mst_av_cycles + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] state, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            state = lfsr_next(state);
            v = (v << 1) | int'(state[0]);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #0.5;
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // memory data rule
    task automatic check_mem_rsp(input string name, input addr_t addr, input rd_rsp_t rsp);
        check_data({name, ".data"}, addr ^ DATA_MASK, rsp.data);
        check_resp({name, ".resp"}, `RESP_OKAY, rsp.resp);
    endtask

    task automatic start_read(input logic is_lsu, input addr_t addr);
        if (is_lsu) begin
            lsu_arvalid = 1'b1;
            lsu_ar.addr = addr;
        end else begin
            ifu_arvalid = 1'b1;
            ifu_ar.addr = addr;
        end
    endtask

    task automatic set_rready(input logic is_lsu, input logic v);
        if (is_lsu) lsu_rready = v;
        else ifu_rready = v;
    endtask

    // wait for the request handshake and drop arvalid
    task automatic finish_request(input logic is_lsu, output int at_cycle);
        logic done;
        int   n;
        done = 1'b0;
        at_cycle = -1;
        for (n = 0; n < 50 && !done; n++) begin
            @(negedge clock);
            done = is_lsu ? lsu_arready : ifu_arready;
            at_cycle = cycle;
            wait_cycles(1);
        end
        if (is_lsu) lsu_arvalid = 1'b0;
        else ifu_arvalid = 1'b0;
        if (!done) begin
            $display("no request handshake on the %s port", is_lsu ? "lsu" : "ifu");
            errors++;
        end
    endtask

    // rready low for hold cycles of rvalid while the payload holds still
    task automatic take_response(input logic is_lsu, input int hold, output rd_rsp_t rsp);
        rd_rsp_t first;
        rd_rsp_t now;
        logic    vld;
        logic    done;
        int      waited;
        int      n;
        string   port;
        port = is_lsu ? "lsu" : "ifu";
        first = '0;
        done = 1'b0;
        waited = 0;
        set_rready(is_lsu, hold == 0);
        for (n = 0; n < 60 && !done; n++) begin
            @(negedge clock);
            vld = is_lsu ? lsu_rvalid : ifu_rvalid;
            now = is_lsu ? lsu_r : ifu_r;
            if (vld) begin
                if (waited == 0) first = now;
                check_data({port, "_r.data"}, first.data, now.data);
                check_resp({port, "_r.resp"}, first.resp, now.resp);
                waited++;
                done = is_lsu ? lsu_rready : ifu_rready;
            end else if (waited > 0) begin
                $display("%s_rvalid dropped before the response was taken", port);
                errors++;
            end
            wait_cycles(1);
            if (vld && waited >= hold) set_rready(is_lsu, 1'b1);
        end
        set_rready(is_lsu, 1'b0);
        rsp = first;
        if (!done) begin
            $display("no response on the %s port", port);
            errors++;
        end
    endtask

    task automatic do_read(input logic is_lsu, input addr_t addr, output rd_rsp_t rsp,
                           output int at_cycle);
        start_read(is_lsu, addr);
        finish_request(is_lsu, at_cycle);
        take_response(is_lsu, 0, rsp);
    endtask

    task automatic test_port_read(input logic is_lsu, input addr_t addr);
        rd_rsp_t rsp;
        int      c;
        int      count0;
        count0 = req_count;
        do_read(is_lsu, addr, rsp, c);
        check_mem_rsp(is_lsu ? "lsu_r" : "ifu_r", addr, rsp);
        check_count("mst request count", count0 + 1, req_count);
    endtask

    task automatic test_arbitration();
        rd_rsp_t rsp;
        int      c;
        int      ifu_hs0;
        ifu_hs0 = ifu_ar_hs;
        start_read(1'b1, 32'h8000_2000);
        start_read(1'b0, 32'h8000_3000);
        finish_request(1'b1, c);
        take_response(1'b1, 0, rsp);
        check_mem_rsp("lsu_r", 32'h8000_2000, rsp);
        check_count("ifu handshakes before lsu response", ifu_hs0, ifu_ar_hs);
        finish_request(1'b0, c);
        take_response(1'b0, 0, rsp);
        check_mem_rsp("ifu_r", 32'h8000_3000, rsp);
    endtask

    task automatic test_timer_reads();
        rd_rsp_t rsp1;
        rd_rsp_t rsp2;
        int      c1;
        int      c2;
        int      gap;
        int      count0;
        count0 = req_count;
        do_read(1'b1, `CLINT_BASE + addr_t'(`MTIME_LO_OFF), rsp1, c1);
        take_bits(3, tb_lfsr, gap);
        wait_cycles(gap);
        do_read(1'b1, `CLINT_BASE + addr_t'(`MTIME_LO_OFF), rsp2, c2);
        check_data("mtime low delta", data_t'(c2 - c1), rsp2.data - rsp1.data);
        check_resp("lsu_r.resp", `RESP_OKAY, rsp1.resp);
        check_resp("lsu_r.resp", `RESP_OKAY, rsp2.resp);
        do_read(1'b1, `CLINT_BASE + addr_t'(`MTIME_HI_OFF), rsp1, c1);
        check_data("mtime high word", 32'h0, rsp1.data);
        check_resp("lsu_r.resp", `RESP_OKAY, rsp1.resp);
        check_count("mst request count", count0, req_count);
    endtask

    task automatic test_bad_offset();
        rd_rsp_t rsp;
        int      c;
        int      av0;
        av0 = mst_av_cycles;
        do_read(1'b0, `CLINT_BASE + 32'h8, rsp, c);
        check_data("ifu_r.data", 32'h0, rsp.data);
        check_resp("ifu_r.resp", `RESP_DECERR, rsp.resp);
        check_count("mst_arvalid cycles", av0, mst_av_cycles);
    endtask

    task automatic test_backpressure();
        rd_rsp_t rsp;
        int      c;
        int      hold;
        int      ifu_hs0;
        take_bits(3, tb_lfsr, hold);
        start_read(1'b1, 32'h8000_4000);
        finish_request(1'b1, c);
        ifu_hs0 = ifu_ar_hs;
        start_read(1'b0, `CLINT_BASE);
        take_response(1'b1, hold + 1, rsp);
        check_mem_rsp("lsu_r", 32'h8000_4000, rsp);
        check_count("ifu handshakes during held read", ifu_hs0, ifu_ar_hs);
        finish_request(1'b0, c);
        take_response(1'b0, 0, rsp);
        check_resp("ifu_r.resp", `RESP_OKAY, rsp.resp);
    endtask

    // memory model on the master port with one read at a time
    initial begin
        addr_t a;
        int    d;
        logic  done;
        mst_arready = 1'b0;
        mst_rvalid = 1'b0;
        mst_r = '0;
        forever begin
            @(negedge clock);
            if (mst_arvalid) begin
                take_bits(2, mem_lfsr, d);
                wait_cycles(d + 1);
                mst_arready = 1'b1;
                @(negedge clock);
                a = mst_ar.addr;
                wait_cycles(1);
                mst_arready = 1'b0;
                req_count++;
                take_bits(2, mem_lfsr, d);
                wait_cycles(d);
                mst_rvalid = 1'b1;
                mst_r.data = a ^ DATA_MASK;
                mst_r.resp = `RESP_OKAY;
                done = 1'b0;
                while (!done) begin
                    @(negedge clock);
                    done = mst_rready;
                    wait_cycles(1);
                end
                mst_rvalid = 1'b0;
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        ifu_arvalid = 1'b0;
        lsu_arvalid = 1'b0;
        ifu_ar = '0;
        lsu_ar = '0;
        ifu_rready = 1'b0;
        lsu_rready = 1'b0;
        repeat (2) @(posedge clock);
        #0.5;
        arst_n = 1'b1;
        wait_cycles(2);
        test_port_read(1'b0, 32'h8000_1000);
        test_port_read(1'b1, 32'h8000_1004);
        test_arbitration();
        test_timer_reads();
        test_bad_offset();
        test_backpressure();
        wait_cycles(2);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
